//--- sim.f
+incdir+include
hw/cpuPkg.sv
hw/opcodeDecoder.sv
hw/timingSequencer.sv
hw/addressGenerator.sv
hw/executeUnit.sv
hw/cpuTop.sv
tests/cpuChecker.sv
tests/cpuTb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing
TOP      = cpuTb
FILELIST = sim.f
BUILDDIR = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILDDIR)
	./$(BUILDDIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Regression failed" $(LOG); then exit 1; fi
	@grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(BUILDDIR) $(LOG)

//--- tests/cpuTb.sv
`default_nettype none

`include "cpu_macros.svh"

module cpuTb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NumTests    = 6;
    localparam int ResetCycles = 8;
    localparam int DrainCycles = 12;

    logic                   clk;
    logic                   nrst;
    logic                   memReady;
    logic [`CPU_DATA_W-1:0] memRdata;
    cpuPkg::memBusT         memBus;
    logic                   halted;
    logic                   testStart;
    logic                   testEnd;
    logic                   watchdogArmed;
    logic [7:0]             mem [0:255];
    logic [7:0]             image [0:255];
    int                     progLen [$];
    int                     stallPct;
    int                     watchdogCycles;
    int                     testsRun;
    int                     testsFailed;
    int                     errorCount;

    cpuTop dut_i (
        .clk      (clk),
        .nrst     (nrst),
        .memReady (memReady),
        .memRdata (memRdata),
        .memBus   (memBus),
        .halted   (halted)
    );

    cpuChecker checkerInst (
        .clk         (clk),
        .nrst        (nrst),
        .memReady    (memReady),
        .memBus      (memBus),
        .halted      (halted),
        .testStart   (testStart),
        .testEnd     (testEnd),
        .image       (image),
        .testsRun    (testsRun),
        .testsFailed (testsFailed),
        .errorCount  (errorCount)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    // Memory with combinational reads and a reload from the image at test start
    assign memRdata = mem[memBus.addr];

    always @(posedge clk) begin : memWrite
        if (testStart) begin
            for (int i = 0; i < 256; i++) begin
                mem[8'(i)] <= image[8'(i)];
            end
        end else if (memReady && memBus.we) begin
            mem[memBus.addr] <= memBus.wdata;
        end
    end

    // Instruction nibble from LDA and the ALU group
    function automatic logic [3:0] loadNibble();
        int pick;
        pick = $urandom_range(0, 5);
        return (pick == 0) ? 4'd1 : 4'(pick + 2);
    endfunction

    // Instruction nibble from STA, JMP and BEQ
    function automatic logic [3:0] targetNibble();
        int pick;
        pick = $urandom_range(0, 2);
        return (pick == 0) ? 4'd2 : 4'(pick + 7);
    endfunction

    task automatic buildProgram(input int len);
        int         kinds [$];
        logic [7:0] starts [$];
        logic [7:0] addr;
        logic [7:0] opByte;
        logic [7:0] operand;
        int         mode;
        int         span;
        // Random data below C0h and pointers into 80h to BFh above
        for (int i = 0; i < 256; i++) begin
            if (i >= 'hc0) begin
                image[8'(i)] = {2'b10, 6'($urandom())};
            end else begin
                image[8'(i)] = 8'($urandom());
            end
        end
        // Kind 0 is NOP or folded, 1 to 5 load or ALU, 6 and 7 store, 8 JMP, 9 BEQ, 10 HLT
        addr = 8'h00;
        for (int i = 0; i < len; i++) begin
            kinds.push_back((i == len - 1) ? 10 : $urandom_range(0, 9));
            starts.push_back(addr);
            addr = addr + ((kinds[i] == 0 || kinds[i] == 10) ? 8'd1 : 8'd2);
        end
        for (int i = 0; i < len; i++) begin
            addr    = starts[i];
            operand = 8'h00;
            case (kinds[i])
                0: begin
                    case ($urandom_range(0, 2))
                        0: opByte = {($urandom_range(0, 5) == 0) ? 4'd0 :
                                     4'($urandom_range(11, 15)), 4'($urandom())};
                        1: opByte = {loadNibble(), 2'($urandom()), 2'b00};
                        default: opByte = {targetNibble(), 2'($urandom()), 1'b0,
                                           1'($urandom())};
                    endcase
                end
                1, 2, 3, 4, 5: begin
                    mode   = $urandom_range(1, 3);
                    opByte = {loadNibble(), 2'($urandom()), 2'(mode)};
                    if (mode == 1) begin
                        // Zero operands often enough to take branches
                        operand = ($urandom_range(0, 3) == 0) ? 8'h00 : 8'($urandom());
                    end else if (mode == 2) begin
                        operand = {2'b10, 6'($urandom())};
                    end else begin
                        operand = {2'b11, 6'($urandom())};
                    end
                end
                6, 7: begin
                    opByte  = {4'd2, 2'($urandom()), 2'd2};
                    operand = {2'b10, 6'($urandom())};
                end
                8, 9: begin
                    opByte  = {(kinds[i] == 8) ? 4'd8 : 4'd9, 2'($urandom()), 2'd2};
                    span    = (len - 2 - i > 3) ? 3 : len - 2 - i;
                    operand = starts[i + 1 + $urandom_range(0, span)];
                end
                default: opByte = {4'd10, 4'($urandom())};
            endcase
            image[addr] = opByte;
            if (kinds[i] != 0 && kinds[i] != 10) begin
                image[addr + 8'd1] = operand;
            end
        end
    endtask

    task automatic runTest(input int testIdx);
        buildProgram(progLen[testIdx]);
        stallPct = $urandom_range(0, 50);
        @(negedge clk);
        nrst     = 1'b0;
        memReady = 1'b1;
        repeat (ResetCycles - 1) @(negedge clk);
        testStart = 1'b1;
        @(negedge clk);
        testStart = 1'b0;
        nrst      = 1'b1;
        while (!halted) begin
            memReady = ($urandom_range(0, 99) >= stallPct);
            @(negedge clk);
        end
        // Keep the bus running to catch late writes
        repeat (DrainCycles) begin
            memReady = ($urandom_range(0, 99) >= stallPct);
            @(negedge clk);
        end
        testEnd = 1'b1;
        @(negedge clk);
        testEnd = 1'b0;
    endtask

    initial begin : mainSequence
        int seedValue;
        nrst          = 1'b0;
        memReady      = 1'b1;
        testStart     = 1'b0;
        testEnd       = 1'b0;
        watchdogArmed = 1'b0;
        seedValue     = 32'h17db;
        void'($urandom(seedValue));
        watchdogCycles = 0;
        for (int t = 0; t < NumTests; t++) begin
            progLen.push_back($urandom_range(20, 40));
            watchdogCycles += 8 * progLen[t] * 4 + ResetCycles + DrainCycles + 4;
        end
        watchdogArmed = 1'b1;
        for (int t = 0; t < NumTests; t++) begin
            runTest(t);
        end
        repeat (2) @(negedge clk);
        $display("Summary: %0d tests run, %0d failed, %0d errors (seed 0x%0h)",
                 testsRun, testsFailed, errorCount, seedValue);
        if (testsRun == NumTests && testsFailed == 0 && errorCount == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    initial begin : watchdog
        wait (watchdogArmed);
        repeat (watchdogCycles) @(posedge clk);
        $display("Timeout: the tests did not finish within %0d cycles", watchdogCycles);
        $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/cpuChecker.sv
`default_nettype none

`include "cpu_macros.svh"

module cpuChecker (
    input  wire logic           clk,
    input  wire logic           nrst,
    input  wire logic           memReady,
    input  wire cpuPkg::memBusT memBus,
    input  wire logic           halted,
    input  wire logic           testStart,
    input  wire logic           testEnd,
    input  wire logic [7:0]     image [0:255],
    output int                  testsRun,
    output int                  testsFailed,
    output int                  errorCount
);
    timeunit 1ns;
    timeprecision 100ps;

    // Instruction codes in opcode nibble order
    localparam int OpNop = 0;
    localparam int OpLda = 1;
    localparam int OpSta = 2;
    localparam int OpAdd = 3;
    localparam int OpSub = 4;
    localparam int OpAnd = 5;
    localparam int OpOra = 6;
    localparam int OpXor = 7;
    localparam int OpJmp = 8;
    localparam int OpBeq = 9;
    localparam int OpHlt = 10;

    logic [7:0] modelMem [0:255];
    logic [7:0] expAddr [$];
    logic [7:0] expData [$];
    int         testErrors;
    int         writesSeen;
    int         expWrites;
    bit         modelHalts;
    bit         armed;
    bit         firstRead;

    task automatic reportMismatch(input string sigName, input int got, input int expected);
        $display("ERROR t=%0t %s: got 0x%0h, expected 0x%0h", $time, sigName, got, expected);
        testErrors++;
        errorCount++;
    endtask

    task automatic reportFailure(input string what);
        $display("FAILURE t=%0t %s", $time, what);
        testErrors++;
        errorCount++;
    endtask

    // Opcode byte to instruction and mode with illegal pairs as NOP
    function automatic void decodeOpcode(input logic [7:0] b, output int ins, output int mode);
        ins  = int'(b[7:4]);
        mode = int'(b[1:0]);
        if (ins > OpHlt) begin
            ins = OpNop;
        end
        if ((ins == OpLda || (ins >= OpAdd && ins <= OpXor)) && mode == 0) begin
            ins = OpNop;
        end
        if ((ins == OpSta || ins == OpJmp || ins == OpBeq) && mode < 2) begin
            ins = OpNop;
        end
        if (ins == OpNop || ins == OpHlt) begin
            mode = 0;
        end
    endfunction

    task automatic runModel();
        logic [7:0] pc;
        logic [7:0] acc;
        logic [7:0] ea;
        logic [7:0] operand;
        logic       zf;
        int         ins;
        int         mode;
        int         steps;
        pc    = 8'h00;
        acc   = 8'h00;
        // Zero flag starts set since the accumulator clears on reset
        zf    = 1'b1;
        steps = 0;
        modelHalts = 1'b0;
        expAddr.delete();
        expData.delete();
        while (!modelHalts && steps < 256) begin
            decodeOpcode(modelMem[pc], ins, mode);
            pc = pc + 8'd1;
            ea = 8'h00;
            if (mode == 1) begin
                ea = pc;
            end else if (mode == 2) begin
                ea = modelMem[pc];
            end else if (mode == 3) begin
                ea = modelMem[modelMem[pc]];
            end
            if (mode != 0) begin
                pc = pc + 8'd1;
            end
            operand = modelMem[ea];
            case (ins)
                OpLda: acc = operand;
                OpAdd: acc = acc + operand;
                OpSub: acc = acc - operand;
                OpAnd: acc = acc & operand;
                OpOra: acc = acc | operand;
                OpXor: acc = acc ^ operand;
                OpSta: begin
                    modelMem[ea] = acc;
                    expAddr.push_back(ea);
                    expData.push_back(acc);
                end
                OpJmp: pc = ea;
                OpBeq: pc = zf ? ea : pc;
                OpHlt: modelHalts = 1'b1;
                default: ;
            endcase
            if (ins == OpLda || (ins >= OpAdd && ins <= OpXor)) begin
                zf = (acc == 8'h00);
            end
            steps++;
        end
        expWrites = expAddr.size();
    endtask

    task automatic checkWrite();
        if (halted) begin
            reportFailure("bus write after halted was raised");
        end
        if (expAddr.size() == 0) begin
            reportFailure("bus write that the model does not predict");
        end else begin
            if (memBus.addr != expAddr[0]) begin
                reportMismatch("memBus.addr", int'(memBus.addr), int'(expAddr[0]));
            end
            if (memBus.wdata != expData[0]) begin
                reportMismatch("memBus.wdata", int'(memBus.wdata), int'(expData[0]));
            end
            expAddr.delete(0);
            expData.delete(0);
        end
        writesSeen++;
    endtask

    task automatic finishTest();
        if (!modelHalts) begin
            reportFailure("model program never reached HLT");
        end
        if (!halted) begin
            reportFailure("halted did not rise after HLT");
        end
        if (writesSeen != expWrites) begin
            reportMismatch("write count", writesSeen, expWrites);
        end
        testsRun++;
        if (testErrors != 0) begin
            testsFailed++;
        end
        $display("Test %0d: %s, %0d of %0d writes, %0d errors", testsRun,
                 (testErrors == 0) ? "PASS" : "FAIL", writesSeen, expWrites, testErrors);
        armed = 1'b0;
    endtask

    always @(posedge clk) begin : compare
        if (testStart) begin
            for (int i = 0; i < 256; i++) begin
                modelMem[8'(i)] = image[8'(i)];
            end
            runModel();
            testErrors = 0;
            writesSeen = 0;
            armed      = 1'b1;
            firstRead  = 1'b1;
            if (memBus.we || halted) begin
                reportFailure("memWe or halted is high during reset");
            end
        end else if (armed) begin
            if (memBus.we && !memReady) begin
                reportFailure("write strobe on a cycle with memReady low");
            end
            if (nrst && memReady) begin
                // First ready cycle reads from address 0
                if (firstRead) begin
                    firstRead = 1'b0;
                    if (memBus.addr != 8'h00) begin
                        reportMismatch("memBus.addr", int'(memBus.addr), 0);
                    end
                end
                if (memBus.we) begin
                    checkWrite();
                end
            end
            if (testEnd) begin
                finishTest();
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/cpuTop.sv
`default_nettype none

`include "cpu_macros.svh"

module cpuTop (
    input  wire logic                   clk,
    input  wire logic                   nrst,
    input  wire logic                   memReady,
    input  wire logic [`CPU_DATA_W-1:0] memRdata,
    output cpuPkg::memBusT              memBus,
    output logic                        halted
);

    cpuPkg::opT             decodedInstruction;
    cpuPkg::addrModeT       decodedAddress;
    cpuPkg::seqStateT       seqState;
    logic                   getInstruction;
    logic                   endAddressing;
    logic                   pcLoad;
    logic                   memWe;
    logic [`CPU_ADDR_W-1:0] effAddr;
    logic [`CPU_ADDR_W-1:0] memAddr;
    logic [`CPU_DATA_W-1:0] memWdata;

    opcodeDecoder decoder (
        .memRdata           (memRdata),
        .decodedInstruction (decodedInstruction),
        .decodedAddress     (decodedAddress)
    );

    timingSequencer sequencer (
        .clk                (clk),
        .nrst               (nrst),
        .memReady           (memReady),
        .getInstruction     (getInstruction),
        .endAddressing      (endAddressing),
        .decodedInstruction (decodedInstruction),
        .decodedAddress     (decodedAddress),
        .seqState           (seqState)
    );

    addressGenerator addrGen (
        .clk            (clk),
        .nrst           (nrst),
        .memReady       (memReady),
        .seqState       (seqState),
        .memRdata       (memRdata),
        .getInstruction (getInstruction),
        .pcLoad         (pcLoad),
        .endAddressing  (endAddressing),
        .effAddr        (effAddr),
        .memAddr        (memAddr)
    );

    executeUnit execUnit (
        .clk            (clk),
        .nrst           (nrst),
        .memReady       (memReady),
        .seqState       (seqState),
        .memRdata       (memRdata),
        .effAddr        (effAddr),
        .memWdata       (memWdata),
        .memWe          (memWe),
        .pcLoad         (pcLoad),
        .getInstruction (getInstruction),
        .halted         (halted)
    );

    // Single byte-wide bus to the outside memory
    assign memBus.addr  = memAddr;
    assign memBus.wdata = memWdata;
    assign memBus.we    = memWe;

endmodule

`default_nettype wire

//--- hw/executeUnit.sv
`default_nettype none

`include "cpu_macros.svh"

module executeUnit (
    input  wire logic                   clk,
    input  wire logic                   nrst,
    input  wire logic                   memReady,
    input  cpuPkg::seqStateT            seqState,
    input  wire logic [`CPU_DATA_W-1:0] memRdata,
    input  wire logic [`CPU_ADDR_W-1:0] effAddr,
    output logic [`CPU_DATA_W-1:0]      memWdata,
    output logic                        memWe,
    output logic                        pcLoad,
    output logic                        getInstruction,
    output logic                        halted
);

    logic [`CPU_DATA_W-1:0] acc;
    logic [`CPU_DATA_W-1:0] aluResult;
    logic                   zeroFlag;
    logic                   inExec;
    logic                   opCycle;
    logic                   writesAcc;
    cpuPkg::opT             instr;

    assign instr   = seqState.instruction;
    assign inExec  = (seqState.phase == cpuPkg::INSTRUCTION);
    // Operand, store and jump work all happen at INSTRUCTION T0
    assign opCycle = inExec && (seqState.timeState == cpuPkg::T0);

    always_comb begin : alu
        writesAcc = 1'b1;
        case (instr)
            cpuPkg::LDA: aluResult = memRdata;
            cpuPkg::ADD: aluResult = acc + memRdata;
            cpuPkg::SUB: aluResult = acc - memRdata;
            cpuPkg::AND: aluResult = acc & memRdata;
            cpuPkg::ORA: aluResult = acc | memRdata;
            cpuPkg::XOR: aluResult = acc ^ memRdata;
            default: begin
                aluResult = acc;
                writesAcc = 1'b0;
            end
        endcase
    end

    assign memWdata = acc;
    assign memWe    = opCycle && (instr == cpuPkg::STA) && memReady;
    assign pcLoad   = opCycle && ((instr == cpuPkg::JMP) ||
                                  (instr == cpuPkg::BEQ && zeroFlag));

    // NOP fetches right away; HLT never fetches
    assign getInstruction = inExec && (instr != cpuPkg::HLT) &&
                            ((instr == cpuPkg::NOP) || (seqState.timeState == cpuPkg::T1));

    always_ff @(posedge clk, negedge nrst) begin : accReg
        if (!nrst) begin
            acc      <= '0;
            zeroFlag <= 1'b1;
        end else if (memReady && opCycle && writesAcc) begin
            acc      <= aluResult;
            zeroFlag <= (aluResult == '0);
        end
    end

    always_ff @(posedge clk, negedge nrst) begin : haltReg
        if (!nrst) begin
            halted <= 1'b0;
        end else if (memReady && inExec && instr == cpuPkg::HLT) begin
            halted <= 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- hw/addressGenerator.sv
`default_nettype none

`include "cpu_macros.svh"

module addressGenerator (
    input  wire logic                   clk,
    input  wire logic                   nrst,
    input  wire logic                   memReady,
    input  cpuPkg::seqStateT            seqState,
    input  wire logic [`CPU_DATA_W-1:0] memRdata,
    input  wire logic                   getInstruction,
    input  wire logic                   pcLoad,
    output logic                        endAddressing,
    output logic [`CPU_ADDR_W-1:0]      effAddr,
    output logic [`CPU_ADDR_W-1:0]      memAddr
);

    logic [`CPU_ADDR_W-1:0] pc;
    logic [`CPU_ADDR_W-1:0] pointer;
    logic                   addrFirst;
    logic                   indirectSecond;
    logic                   hasOperand;

    assign addrFirst = (seqState.phase == cpuPkg::ADDRESS) &&
                       (seqState.timeState == cpuPkg::T0);
    assign indirectSecond = (seqState.phase == cpuPkg::ADDRESS) &&
                            (seqState.timeState == cpuPkg::T1) &&
                            (seqState.addrMode == cpuPkg::INDIRECT);
    assign hasOperand = (seqState.addrMode != cpuPkg::IMPLIED);

    // Indirect needs a second cycle to follow the pointer
    assign endAddressing = (addrFirst && (seqState.addrMode == cpuPkg::IMMEDIATE ||
                                          seqState.addrMode == cpuPkg::ABSOLUTE)) ||
                           indirectSecond;

    // Bus address source
    always_comb begin : addrSelect
        if (getInstruction || addrFirst) begin
            memAddr = pc;
        end else if (indirectSecond) begin
            memAddr = pointer;
        end else begin
            memAddr = effAddr;
        end
    end

    always_ff @(posedge clk, negedge nrst) begin : pcReg
        if (!nrst) begin
            pc <= '0;
        end else if (memReady) begin
            if (pcLoad) begin
                pc <= effAddr;
            end else if (getInstruction || (addrFirst && hasOperand)) begin
                pc <= pc + 1'b1;
            end
        end
    end

    always_ff @(posedge clk, negedge nrst) begin : effAddrReg
        if (!nrst) begin
            effAddr <= '0;
        end else if (memReady) begin
            if (addrFirst && seqState.addrMode == cpuPkg::IMMEDIATE) begin
                // Operand is the byte right after the opcode
                effAddr <= pc;
            end else if ((addrFirst && seqState.addrMode == cpuPkg::ABSOLUTE) ||
                         indirectSecond) begin
                effAddr <= memRdata;
            end
        end
    end

    always_ff @(posedge clk) begin : pointerReg
        if (memReady && addrFirst && seqState.addrMode == cpuPkg::INDIRECT) begin
            pointer <= memRdata;
        end
    end

endmodule

`default_nettype wire

//--- hw/timingSequencer.sv
`default_nettype none

module timingSequencer (
    input  wire logic         clk,
    input  wire logic         nrst,
    input  wire logic         memReady,
    input  wire logic         getInstruction,
    input  wire logic         endAddressing,
    input  cpuPkg::opT        decodedInstruction,
    input  cpuPkg::addrModeT  decodedAddress,
    output cpuPkg::seqStateT  seqState
);

    cpuPkg::seqStateT nextState;
    logic             noAddressing;

    // Implied instructions skip straight into the INSTRUCTION phase
    assign noAddressing = (seqState.addrMode == cpuPkg::IMPLIED);

    always_comb begin : nextTiming
        nextState = seqState;

        if (endAddressing) begin
            // Last addressing cycle
            nextState.phase     = cpuPkg::INSTRUCTION;
            nextState.timeState = cpuPkg::T0;
        end else if (getInstruction) begin
            // Fetch cycle ends the instruction
            nextState.phase     = cpuPkg::ADDRESS;
            nextState.timeState = cpuPkg::T0;
        end else begin
            case (seqState.timeState)
                cpuPkg::T0: nextState.timeState = cpuPkg::T1;
                cpuPkg::T1: nextState.timeState = cpuPkg::T2;
                cpuPkg::T2: nextState.timeState = cpuPkg::T3;
                cpuPkg::T3: nextState.timeState = cpuPkg::T4;
                cpuPkg::T4: nextState.timeState = cpuPkg::T5;
                cpuPkg::T5: nextState.timeState = cpuPkg::T6;
                default:    nextState.timeState = cpuPkg::T0;
            endcase
        end

        if (seqState.phase == cpuPkg::ADDRESS && noAddressing) begin
            nextState.phase = cpuPkg::INSTRUCTION;
        end

        // Opcode byte is on the bus during the fetch cycle
        if (getInstruction) begin
            nextState.instruction = decodedInstruction;
            nextState.addrMode    = decodedAddress;
        end

        // Stalled bus freezes the whole sequence
        if (!memReady) begin
            nextState = seqState;
        end
    end

    always_ff @(posedge clk, negedge nrst) begin : stateReg
        if (!nrst) begin
            seqState.phase       <= cpuPkg::ADDRESS;
            seqState.timeState   <= cpuPkg::T0;
            seqState.instruction <= cpuPkg::NOP;
            seqState.addrMode    <= cpuPkg::IMPLIED;
        end else begin
            seqState <= nextState;
        end
    end

endmodule

`default_nettype wire

//--- hw/opcodeDecoder.sv
`default_nettype none

`include "cpu_macros.svh"

module opcodeDecoder (
    input  wire logic [`CPU_DATA_W-1:0] memRdata,
    output cpuPkg::opT                  decodedInstruction,
    output cpuPkg::addrModeT            decodedAddress
);

    cpuPkg::opT       rawOp;
    cpuPkg::addrModeT rawMode;
    logic             illegal;

    // Upper nibble picks the instruction and unused codes give NOP
    always_comb begin : rawDecode
        case (memRdata[7:4])
            4'd1:    rawOp = cpuPkg::LDA;
            4'd2:    rawOp = cpuPkg::STA;
            4'd3:    rawOp = cpuPkg::ADD;
            4'd4:    rawOp = cpuPkg::SUB;
            4'd5:    rawOp = cpuPkg::AND;
            4'd6:    rawOp = cpuPkg::ORA;
            4'd7:    rawOp = cpuPkg::XOR;
            4'd8:    rawOp = cpuPkg::JMP;
            4'd9:    rawOp = cpuPkg::BEQ;
            4'd10:   rawOp = cpuPkg::HLT;
            default: rawOp = cpuPkg::NOP;
        endcase
        case (memRdata[1:0])
            2'd1:    rawMode = cpuPkg::IMMEDIATE;
            2'd2:    rawMode = cpuPkg::ABSOLUTE;
            2'd3:    rawMode = cpuPkg::INDIRECT;
            default: rawMode = cpuPkg::IMPLIED;
        endcase
    end

    // Combinations with no operand source or no target fold to NOP
    always_comb begin : foldIllegal
        case (rawOp)
            cpuPkg::LDA, cpuPkg::ADD, cpuPkg::SUB,
            cpuPkg::AND, cpuPkg::ORA, cpuPkg::XOR:
                illegal = (rawMode == cpuPkg::IMPLIED);
            cpuPkg::STA, cpuPkg::JMP, cpuPkg::BEQ:
                illegal = (rawMode == cpuPkg::IMPLIED) || (rawMode == cpuPkg::IMMEDIATE);
            default:
                illegal = 1'b0;
        endcase
        decodedInstruction = illegal ? cpuPkg::NOP : rawOp;
        // NOP and HLT never address memory
        if (decodedInstruction == cpuPkg::NOP || decodedInstruction == cpuPkg::HLT) begin
            decodedAddress = cpuPkg::IMPLIED;
        end else begin
            decodedAddress = rawMode;
        end
    end

endmodule

`default_nettype wire

//--- hw/cpuPkg.sv
`default_nettype none

`include "cpu_macros.svh"

package cpuPkg;

    // Each instruction alternates between these two phases
    typedef enum logic {
        ADDRESS     = 1'b0,
        INSTRUCTION = 1'b1
    } phaseT;

    typedef enum logic [`CPU_TIME_W-1:0] {
        T0 = 3'd0,
        T1 = 3'd1,
        T2 = 3'd2,
        T3 = 3'd3,
        T4 = 3'd4,
        T5 = 3'd5,
        T6 = 3'd6
    } timeStateT;

    // Order follows opcode bits 7 to 4
    typedef enum logic [`CPU_OP_W-1:0] {
        NOP = 6'd0,
        LDA = 6'd1,
        STA = 6'd2,
        ADD = 6'd3,
        SUB = 6'd4,
        AND = 6'd5,
        ORA = 6'd6,
        XOR = 6'd7,
        JMP = 6'd8,
        BEQ = 6'd9,
        HLT = 6'd10
    } opT;

    typedef enum logic [`CPU_AM_W-1:0] {
        IMPLIED   = 4'b0001,
        IMMEDIATE = 4'b0010,
        ABSOLUTE  = 4'b0100,
        INDIRECT  = 4'b1000
    } addrModeT;

    // Sequencer state shared by address generator and execute unit
    typedef struct packed {
        phaseT     phase;
        timeStateT timeState;
        opT        instruction;
        addrModeT  addrMode;
    } seqStateT;

    typedef struct packed {
        logic [`CPU_ADDR_W-1:0] addr;
        logic [`CPU_DATA_W-1:0] wdata;
        logic                   we;
    } memBusT;

endpackage

`default_nettype wire

//--- include/cpu_macros.svh
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// Data byte and bus address widths
`define CPU_DATA_W 8
`define CPU_ADDR_W 8

// Decoded instruction code
`define CPU_OP_W 6

// One-hot addressing mode
`define CPU_AM_W 4

// T0 to T6 within a phase
`define CPU_TIME_W 3

`endif
